// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - design/exec_pkg.sv
  - design/exec_capture.sv
  - design/exec_int_unit.sv
  - design/exec_mem_req.sv
  - design/exec_branch_unit.sv
  - design/exec_stage.sv
  - target: test
    files:
      - tb/tb_exec_stage.sv

// ==== design/exec_branch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_branch_unit
    import exec_pkg::*;
(
    input  logic [xlen-1:0]     cap_pc,
    input  logic [opcode_w-1:0] cap_opcode,
    input  logic [xlen-1:0]     cap_rs1,
    input  logic [xlen-1:0]     cap_rs2,
    input  exec_imm_t           cap_imm,
    output logic                jmp_do,
    output logic [xlen-1:0]     jmp_pc
);

    logic [6:0]      major;
    logic [2:0]      funct3;
    logic [xlen-1:0] rel_target;
    logic [xlen-1:0] reg_target;

    assign major      = cap_opcode[16:10];
    assign funct3     = cap_opcode[9:7];
    assign rel_target = cap_pc + {{19{cap_imm.b_view.val[11]}}, cap_imm.b_view.val, 1'b0};
    assign reg_target = (cap_rs1 + {{20{cap_imm.i_view.val[11]}}, cap_imm.i_view.val})
                        & ~32'd1;

    always_comb begin
        jmp_do = 1'b0;
        jmp_pc = '0;
        if (major == op_branch) begin
            jmp_pc = rel_target;  // target shown even when not taken
            case (funct3)
                f3_beq:  jmp_do = cap_rs1 == cap_rs2;
                f3_bne:  jmp_do = cap_rs1 != cap_rs2;
                f3_blt:  jmp_do = $signed(cap_rs1) < $signed(cap_rs2);
                f3_bge:  jmp_do = $signed(cap_rs1) >= $signed(cap_rs2);
                f3_bltu: jmp_do = cap_rs1 < cap_rs2;
                f3_bgeu: jmp_do = cap_rs1 >= cap_rs2;
                default: jmp_pc = '0;
            endcase
        end else if (major == op_jal) begin
            jmp_do = 1'b1;
            jmp_pc = rel_target;
        end else if (major == op_jalr && funct3 == f3_jalr) begin
            jmp_do = 1'b1;
            jmp_pc = reg_target;
        end
    end

    always_comb begin
        a_jmp_aligned : assert final (!jmp_do || !jmp_pc[0])
            else $error("jump target has bit 0 set");
    end

endmodule

`default_nettype wire

// ==== design/exec_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_capture
    import exec_pkg::*;
(
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  stall,
    input  logic                  mem_wait,
    input  logic                  allow,
    input  logic [xlen-1:0]       pc,
    input  logic [opcode_w-1:0]   opcode,
    input  logic [reg_addr_w-1:0] rd_addr,
    input  logic [xlen-1:0]       rs1_data,
    input  logic [xlen-1:0]       rs2_data,
    input  exec_imm_t             imm,
    output logic                  exec_valid,
    output logic [xlen-1:0]       cap_pc,
    output logic [opcode_w-1:0]   cap_opcode,
    output logic [reg_addr_w-1:0] cap_rd,
    output logic [xlen-1:0]       cap_rs1,
    output logic [xlen-1:0]       cap_rs2,
    output exec_imm_t             cap_imm
);

    logic load_bubble;

    // stall only counts when memory is not holding the stage
    assign load_bubble = rst || flush || (stall && !mem_wait);

    always_ff @(posedge CLK) begin
        if (load_bubble) begin
            exec_valid <= 1'b0;
            cap_pc     <= '0;
            cap_opcode <= '0;
            cap_rd     <= '0;
            cap_rs1    <= '0;
            cap_rs2    <= '0;
            cap_imm    <= '0;
        end else if (!mem_wait) begin
            exec_valid <= allow;
            cap_pc     <= pc;
            cap_opcode <= allow ? opcode : '0;  // dead slot decodes to nothing
            cap_rd     <= rd_addr;
            cap_rs1    <= rs1_data;
            cap_rs2    <= rs2_data;
            cap_imm    <= imm;
        end
    end

    a_stall_bubble : assert property (
        @(posedge CLK) disable iff (rst)
        (stall && !mem_wait) |=> !exec_valid
    ) else $error("exec_valid high after a stalled edge");

endmodule

`default_nettype wire

// ==== design/exec_int_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_int_unit
    import exec_pkg::*;
(
    input  logic [xlen-1:0]       cap_pc,
    input  logic [opcode_w-1:0]   cap_opcode,
    input  logic [reg_addr_w-1:0] cap_rd,
    input  logic [xlen-1:0]       cap_rs1,
    input  logic [xlen-1:0]       cap_rs2,
    input  exec_imm_t             cap_imm,
    output logic                  reg_w_en,
    output logic [reg_addr_w-1:0] reg_w_rd,
    output logic [xlen-1:0]       reg_w_data
);

    logic [6:0]      major;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            is_reg;
    logic            is_imm;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] sra_res;
    logic            alu_ok;
    logic [xlen-1:0] alu_res;

    assign major  = cap_opcode[16:10];
    assign funct3 = cap_opcode[9:7];
    assign funct7 = cap_opcode[6:0];
    assign is_reg = major == op_reg;
    assign is_imm = major == op_imm;

    assign imm_i   = {{20{cap_imm.i_view.val[11]}}, cap_imm.i_view.val};
    assign imm_u   = {cap_imm.u_view.val, 12'b0};
    assign op_b    = is_reg ? cap_rs2 : imm_i;
    assign shamt   = op_b[4:0];  // rs2 or imm bits 4:0
    assign sra_res = $signed(cap_rs1) >>> shamt;

    always_comb begin
        alu_ok  = !is_reg || funct7 == f7_base;
        alu_res = '0;
        case (funct3)
            f3_add: begin
                alu_ok  = !is_reg || funct7 == f7_base || funct7 == f7_alt;
                alu_res = (is_reg && funct7 == f7_alt) ? cap_rs1 - op_b : cap_rs1 + op_b;
            end
            f3_sll: begin
                alu_ok  = funct7 == f7_base;  // shifts check funct7 in both forms
                alu_res = cap_rs1 << shamt;
            end
            f3_slt: begin
                alu_res = {{(xlen-1){1'b0}}, $signed(cap_rs1) < $signed(op_b)};
            end
            f3_sltu: begin
                alu_res = {{(xlen-1){1'b0}}, cap_rs1 < op_b};
            end
            f3_xor: begin
                alu_res = cap_rs1 ^ op_b;
            end
            f3_srl: begin
                alu_ok  = funct7 == f7_base || funct7 == f7_alt;
                alu_res = (funct7 == f7_alt) ? sra_res : cap_rs1 >> shamt;
            end
            f3_or: begin
                alu_res = cap_rs1 | op_b;
            end
            f3_and: begin
                alu_res = cap_rs1 & op_b;
            end
        endcase
    end

    always_comb begin
        reg_w_en   = 1'b1;
        reg_w_rd   = cap_rd;
        reg_w_data = '0;
        if ((is_reg || is_imm) && alu_ok) begin
            reg_w_data = alu_res;
        end else if (major == op_lui) begin
            reg_w_data = imm_u;
        end else if (major == op_auipc) begin
            reg_w_data = cap_pc + imm_u;
        end else if (major == op_jal || (major == op_jalr && funct3 == f3_jalr)) begin
            reg_w_data = cap_pc + 32'd4;  // link
        end else begin
            reg_w_en = 1'b0;  // loads land here too
            reg_w_rd = '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/exec_mem_req.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_mem_req
    import exec_pkg::*;
(
    input  logic [opcode_w-1:0]   cap_opcode,
    input  logic [reg_addr_w-1:0] cap_rd,
    input  logic [xlen-1:0]       cap_rs1,
    input  logic [xlen-1:0]       cap_rs2,
    input  exec_imm_t             cap_imm,
    output logic                  mem_r_en,
    output logic [reg_addr_w-1:0] mem_r_rd,
    output logic [xlen-1:0]       mem_r_addr,
    output logic [3:0]            mem_r_strb,
    output logic                  mem_r_signed,
    output logic                  mem_w_en,
    output logic [xlen-1:0]       mem_w_addr,
    output logic [3:0]            mem_w_strb,
    output logic [xlen-1:0]       mem_w_data
);

    logic [6:0]      major;
    logic [2:0]      funct3;
    logic [xlen-1:0] addr;

    assign major  = cap_opcode[16:10];
    assign funct3 = cap_opcode[9:7];
    assign addr   = cap_rs1 + {{20{cap_imm.i_view.val[11]}}, cap_imm.i_view.val};

    always_comb begin
        mem_r_strb   = '0;
        mem_r_signed = 1'b0;
        if (major == op_load) begin
            case (funct3)
                f3_lb: begin
                    mem_r_strb   = strb_byte;
                    mem_r_signed = 1'b1;
                end
                f3_lbu: mem_r_strb = strb_byte;
                f3_lh: begin
                    mem_r_strb   = strb_half;
                    mem_r_signed = 1'b1;
                end
                f3_lhu: mem_r_strb = strb_half;
                f3_lw:  mem_r_strb = strb_word;
                default: ;  // reserved width
            endcase
        end
        mem_r_en   = mem_r_strb != '0;
        mem_r_rd   = mem_r_en ? cap_rd : '0;
        mem_r_addr = mem_r_en ? addr : '0;
    end

    always_comb begin
        mem_w_strb = '0;
        if (major == op_store) begin
            case (funct3)
                f3_sb:   mem_w_strb = strb_byte;
                f3_sh:   mem_w_strb = strb_half;
                f3_sw:   mem_w_strb = strb_word;
                default: ;
            endcase
        end
        mem_w_en   = mem_w_strb != '0;
        mem_w_addr = mem_w_en ? addr : '0;
        mem_w_data = mem_w_en ? cap_rs2 : '0;  // unaligned lanes left to the bus
    end

    always_comb begin
        a_rw_exclusive : assert final (!(mem_r_en && mem_w_en))
            else $error("load and store requested together");
    end

endmodule

`default_nettype wire

// ==== design/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    localparam int xlen       = 32;
    localparam int opcode_w   = 17;  // major, funct3, funct7
    localparam int reg_addr_w = 5;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;  // shared with sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_jalr = 3'b000;

    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;  // sub, sra

    localparam logic [3:0] strb_byte = 4'b0001;
    localparam logic [3:0] strb_half = 4'b0011;
    localparam logic [3:0] strb_word = 4'b1111;

    typedef union packed {
        struct packed {
            logic [19:0] ext;
            logic [11:0] val;
        } i_view;
        struct packed {
            logic [19:0] val;
            logic [11:0] low;
        } u_view;
        struct packed {
            logic [18:0] ext;
            logic [11:0] val;  // offset bits 12:1
            logic        zero;
        } b_view;
    } exec_imm_t;

endpackage

`default_nettype wire

// ==== design/exec_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_stage
    import exec_pkg::*;
(
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  stall,
    input  logic                  mem_wait,
    input  logic                  allow,
    input  logic [xlen-1:0]       pc,
    input  logic [opcode_w-1:0]   opcode,
    input  logic [reg_addr_w-1:0] rd_addr,
    input  logic [xlen-1:0]       rs1_data,
    input  logic [xlen-1:0]       rs2_data,
    input  exec_imm_t             imm,
    output logic                  exec_valid,
    output logic [xlen-1:0]       exec_pc,
    output logic                  reg_w_en,
    output logic [reg_addr_w-1:0] reg_w_rd,
    output logic [xlen-1:0]       reg_w_data,
    output logic                  mem_r_en,
    output logic [reg_addr_w-1:0] mem_r_rd,
    output logic [xlen-1:0]       mem_r_addr,
    output logic [3:0]            mem_r_strb,
    output logic                  mem_r_signed,
    output logic                  mem_w_en,
    output logic [xlen-1:0]       mem_w_addr,
    output logic [3:0]            mem_w_strb,
    output logic [xlen-1:0]       mem_w_data,
    output logic                  jmp_do,
    output logic [xlen-1:0]       jmp_pc
);

    logic [xlen-1:0]       cap_pc;
    logic [opcode_w-1:0]   cap_opcode;
    logic [reg_addr_w-1:0] cap_rd;
    logic [xlen-1:0]       cap_rs1;
    logic [xlen-1:0]       cap_rs2;
    exec_imm_t             cap_imm;

    assign exec_pc = cap_pc;

    exec_capture i_capture (
        .CLK        (CLK),
        .rst        (rst),
        .flush      (flush),
        .stall      (stall),
        .mem_wait   (mem_wait),
        .allow      (allow),
        .pc         (pc),
        .opcode     (opcode),
        .rd_addr    (rd_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .exec_valid (exec_valid),
        .cap_pc     (cap_pc),
        .cap_opcode (cap_opcode),
        .cap_rd     (cap_rd),
        .cap_rs1    (cap_rs1),
        .cap_rs2    (cap_rs2),
        .cap_imm    (cap_imm)
    );

    exec_int_unit i_int_unit (
        .cap_pc     (cap_pc),
        .cap_opcode (cap_opcode),
        .cap_rd     (cap_rd),
        .cap_rs1    (cap_rs1),
        .cap_rs2    (cap_rs2),
        .cap_imm    (cap_imm),
        .reg_w_en   (reg_w_en),
        .reg_w_rd   (reg_w_rd),
        .reg_w_data (reg_w_data)
    );

    exec_mem_req i_mem_req (
        .cap_opcode   (cap_opcode),
        .cap_rd       (cap_rd),
        .cap_rs1      (cap_rs1),
        .cap_rs2      (cap_rs2),
        .cap_imm      (cap_imm),
        .mem_r_en     (mem_r_en),
        .mem_r_rd     (mem_r_rd),
        .mem_r_addr   (mem_r_addr),
        .mem_r_strb   (mem_r_strb),
        .mem_r_signed (mem_r_signed),
        .mem_w_en     (mem_w_en),
        .mem_w_addr   (mem_w_addr),
        .mem_w_strb   (mem_w_strb),
        .mem_w_data   (mem_w_data)
    );

    exec_branch_unit i_branch_unit (
        .cap_pc     (cap_pc),
        .cap_opcode (cap_opcode),
        .cap_rs1    (cap_rs1),
        .cap_rs2    (cap_rs2),
        .cap_imm    (cap_imm),
        .jmp_do     (jmp_do),
        .jmp_pc     (jmp_pc)
    );

endmodule

`default_nettype wire

// ==== list.f ====
design/exec_pkg.sv
design/exec_capture.sv
design/exec_int_unit.sv
design/exec_mem_req.sv
design/exec_branch_unit.sv
design/exec_stage.sv
tb/tb_exec_stage.sv

// ==== tb/tb_exec_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_exec_stage
    import exec_pkg::*;
();

    logic                  CLK;
    logic                  rst;
    logic                  flush;
    logic                  stall;
    logic                  mem_wait;
    logic                  allow;
    logic [xlen-1:0]       pc;
    logic [opcode_w-1:0]   opcode;
    logic [reg_addr_w-1:0] rd_addr;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    exec_imm_t             imm;
    logic                  exec_valid;
    logic [xlen-1:0]       exec_pc;
    logic                  reg_w_en;
    logic [reg_addr_w-1:0] reg_w_rd;
    logic [xlen-1:0]       reg_w_data;
    logic                  mem_r_en;
    logic [reg_addr_w-1:0] mem_r_rd;
    logic [xlen-1:0]       mem_r_addr;
    logic [3:0]            mem_r_strb;
    logic                  mem_r_signed;
    logic                  mem_w_en;
    logic [xlen-1:0]       mem_w_addr;
    logic [3:0]            mem_w_strb;
    logic [xlen-1:0]       mem_w_data;
    logic                  jmp_do;
    logic [xlen-1:0]       jmp_pc;

    // p_* is what the next capture should bring
    logic [32:0]  exp_val, p_val;
    logic [37:0]  exp_reg, p_reg;
    logic [111:0] exp_mem, p_mem;
    logic [32:0]  exp_jmp, p_jmp;
    logic [2:0]   ld_f3 [5];
    logic [2:0]   st_f3 [3];
    logic [2:0]   br_f3 [6];

    exec_stage i_exec_stage (.*);

    always #20 CLK = ~CLK;

    task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                   input logic [127:0] act_v);
        $display("** Error %s: expected %0h, actual %0h", name, exp_v, act_v);
        $display("TEST FAILED");
        $fatal(1, "output mismatch in %s", name);
    endtask

    task automatic wait_state(input logic want, input string what);
        int n;
        n = 0;
        @(negedge CLK);
        while (exec_valid !== want) begin
            if (n == 8) begin
                $display("timeout: exec_valid never became %0b while waiting for %s", want, what);
                $display("TEST FAILED");
                $fatal(1, "wait timeout");
            end else begin
                n++;
                @(negedge CLK);
            end
        end
    endtask

    // drives one instruction and works out what the stage must show for it
    task automatic issue(input logic [6:0] op7, input logic [2:0] f3, input logic [6:0] f7,
                         input logic ena, input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        exec_imm_t             iv;
        logic [xlen-1:0]       pcv, ii, iu, ib, opb, res, ea;
        logic [reg_addr_w-1:0] rd;
        logic [3:0]            strb;
        logic                  sgn, take;
        iv       = $urandom();
        pcv      = $urandom() & ~32'd3;
        rd       = $urandom();
        allow    = ena;
        pc       = pcv;
        opcode   = {op7, f3, f7};
        rd_addr  = rd;
        rs1_data = a;
        rs2_data = b;
        imm      = iv;
        ii   = {{20{iv.i_view.val[11]}}, iv.i_view.val};
        iu   = {iv.u_view.val, 12'h000};
        ib   = {{19{iv.b_view.val[11]}}, iv.b_view.val, 1'b0};
        ea   = a + ii;
        strb = (f3[1:0] == 2'b00) ? strb_byte : (f3[1:0] == 2'b01) ? strb_half : strb_word;
        sgn  = !f3[2] && f3[1:0] != 2'b10;  // lb, lh
        p_val = {ena, pcv};
        p_reg = '0;
        p_mem = '0;
        p_jmp = '0;
        if (ena) begin
            case (op7)
                op_reg, op_imm: begin
                    opb = (op7 == op_reg) ? b : ii;
                    case (f3)
                        f3_add:  res = (op7 == op_reg && f7 == f7_alt) ? a - opb : a + opb;
                        f3_sll:  res = a << opb[4:0];
                        f3_slt:  res = {31'h0, $signed(a) < $signed(opb)};
                        f3_sltu: res = {31'h0, a < opb};
                        f3_xor:  res = a ^ opb;
                        f3_or:   res = a | opb;
                        f3_and:  res = a & opb;
                        default: begin
                            if (f7 == f7_alt)
                                res = $signed(a) >>> opb[4:0];
                            else
                                res = a >> opb[4:0];
                        end
                    endcase
                    p_reg = {1'b1, rd, res};
                end
                op_lui:   p_reg = {1'b1, rd, iu};
                op_auipc: p_reg = {1'b1, rd, pcv + iu};
                op_jal: begin
                    p_reg = {1'b1, rd, pcv + 32'd4};
                    p_jmp = {1'b1, pcv + ib};
                end
                op_jalr: begin
                    p_reg = {1'b1, rd, pcv + 32'd4};
                    p_jmp = {1'b1, ea & ~32'd1};
                end
                op_load:  p_mem = {1'b1, rd, ea, strb, sgn, 1'b0, 32'h0, 4'h0, 32'h0};
                op_store: p_mem = {1'b0, 5'h0, 32'h0, 4'h0, 1'b0, 1'b1, ea, strb, b};
                op_branch: begin
                    case (f3)
                        f3_beq:  take = a == b;
                        f3_bne:  take = a != b;
                        f3_blt:  take = $signed(a) < $signed(b);
                        f3_bge:  take = $signed(a) >= $signed(b);
                        f3_bltu: take = a < b;
                        default: take = a >= b;
                    endcase
                    p_jmp = {take, pcv + ib};
                end
                default: ;
            endcase
        end
    endtask

    // reference model of the stage register
    always @(posedge CLK) begin
        if (rst || flush) begin
            exp_val <= '0;
            exp_reg <= '0;
            exp_mem <= '0;
            exp_jmp <= '0;
        end else if (!mem_wait) begin
            exp_val <= stall ? '0 : p_val;  // stall loads a bubble
            exp_reg <= stall ? '0 : p_reg;
            exp_mem <= stall ? '0 : p_mem;
            exp_jmp <= stall ? '0 : p_jmp;
        end
    end

    a_valid : assert property (@(posedge CLK) disable iff (rst)
        {exec_valid, exec_pc} == exp_val)
        else report_mismatch("valid", $sampled(exp_val), $sampled({exec_valid, exec_pc}));

    a_reg : assert property (@(posedge CLK) disable iff (rst)
        {reg_w_en, reg_w_rd, reg_w_data} == exp_reg)
        else report_mismatch("reg write", $sampled(exp_reg),
                             $sampled({reg_w_en, reg_w_rd, reg_w_data}));

    a_mem : assert property (@(posedge CLK) disable iff (rst)
        {mem_r_en, mem_r_rd, mem_r_addr, mem_r_strb, mem_r_signed,
         mem_w_en, mem_w_addr, mem_w_strb, mem_w_data} == exp_mem)
        else report_mismatch("mem request", $sampled(exp_mem),
                             $sampled({mem_r_en, mem_r_rd, mem_r_addr, mem_r_strb,
                                       mem_r_signed, mem_w_en, mem_w_addr,
                                       mem_w_strb, mem_w_data}));

    a_jmp : assert property (@(posedge CLK) disable iff (rst)
        {jmp_do, jmp_pc} == exp_jmp)
        else report_mismatch("jump", $sampled(exp_jmp), $sampled({jmp_do, jmp_pc}));

    initial begin
        int              k;
        logic [6:0]      op7;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [xlen-1:0] a, b;
        CLK      = 1'b0;
        rst      = 1'b1;
        flush    = 1'b0;
        stall    = 1'b0;
        mem_wait = 1'b0;
        allow    = 1'b0;
        pc       = '0;
        opcode   = '0;
        rd_addr  = '0;
        rs1_data = '0;
        rs2_data = '0;
        imm      = '0;
        p_val    = '0;
        p_reg    = '0;
        p_mem    = '0;
        p_jmp    = '0;
        ld_f3    = '{f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu};
        st_f3    = '{f3_sb, f3_sh, f3_sw};
        br_f3    = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
        void'($urandom(32'hb251));
        repeat (3) @(negedge CLK);
        rst = 1'b0;

        repeat (40) begin
            k   = $urandom_range(3, 0);
            op7 = (k == 0) ? op_reg : (k == 1) ? op_imm : (k == 2) ? op_lui : op_auipc;
            f3  = $urandom();
            f7  = ($urandom_range(1, 0) == 1) ? f7_alt : f7_base;
            if (f3 != f3_add && f3 != f3_srl)
                f7 = f7_base;
            if (k == 1 && f3 != f3_sll && f3 != f3_srl)
                f7 = $urandom();  // immediate forms ignore funct7
            issue(op7, f3, f7, 1'b1, $urandom(), $urandom());
            wait_state(1'b1, "alu result");
        end

        repeat (20) begin
            if ($urandom_range(1, 0) == 1)
                issue(op_load, ld_f3[$urandom_range(4, 0)], $urandom(), 1'b1,
                      $urandom(), $urandom());
            else
                issue(op_store, st_f3[$urandom_range(2, 0)], $urandom(), 1'b1,
                      $urandom(), $urandom());
            wait_state(1'b1, "memory request");
        end

        for (int c = 0; c < 6; c++) begin
            for (int v = 0; v < 4; v++) begin
                a = $urandom();
                b = (v == 0) ? a : $urandom();
                if (v == 2) begin
                    a[31] = 1'b1;  // negative against positive
                    b[31] = 1'b0;
                end
                if (v == 3) begin
                    a[31] = 1'b0;
                    b[31] = 1'b1;
                end
                issue(op_branch, br_f3[c], f7_base, 1'b1, a, b);
                wait_state(1'b1, "branch");
            end
        end
        repeat (6) begin
            issue(op_jal, $urandom(), $urandom(), 1'b1, $urandom(), $urandom());
            wait_state(1'b1, "jal");
            issue(op_jalr, f3_jalr, f7_base, 1'b1, $urandom(), $urandom());
            wait_state(1'b1, "jalr");
        end

        issue(op_lui, f3_add, f7_base, 1'b1, $urandom(), $urandom());
        wait_state(1'b1, "instruction before mem_wait");
        mem_wait = 1'b1;
        repeat (4) begin
            issue(op_reg, f3_xor, f7_base, 1'b1, $urandom(), $urandom());  // ignored
            wait_state(1'b1, "held instruction");
        end
        mem_wait = 1'b0;
        issue(op_auipc, f3_add, f7_base, 1'b1, $urandom(), $urandom());
        wait_state(1'b1, "release of mem_wait");
        stall = 1'b1;
        issue(op_reg, f3_add, f7_base, 1'b1, $urandom(), $urandom());
        wait_state(1'b0, "stall bubble");
        stall = 1'b0;
        issue(op_store, f3_sw, f7_base, 1'b1, $urandom(), $urandom());
        wait_state(1'b1, "store after stall");
        flush = 1'b1;
        issue(op_jal, f3_add, f7_base, 1'b1, $urandom(), $urandom());
        wait_state(1'b0, "flush");
        flush = 1'b0;
        issue(op_load, f3_lw, f7_base, 1'b0, $urandom(), $urandom());
        wait_state(1'b0, "slot with allow low");
        issue(op_load, f3_lh, f7_base, 1'b1, $urandom(), $urandom());
        wait_state(1'b1, "last load");
        issue(op_reg, f3_add, f7_base, 1'b0, $urandom(), $urandom());
        wait_state(1'b0, "drain");

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
